// File: ifu_lite.f
+incdir+rtl
rtl/ifu_pkg.sv
rtl/ifu_bus_watchdog.sv
rtl/ifu_fetch_buf.sv
rtl/ifu_fetch_ctl.sv
rtl/ifu_aligner.sv
rtl/ifu_top.sv
sim/ifu_wb_mem.sv
sim/ifu_checker.sv
sim/ifu_tb.sv

// File: rtl/ifu_aligner.sv
/* aligner: walks the head fetch group halfword by halfword and hands one
   16-bit or 32-bit instruction at a time to decode */

`timescale 1ns/100ps
`default_nettype none

module ifu_aligner (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  flush,
   input  logic                  head_valid,
   input  ifu_pkg::fetch_entry_t head,
   output logic                  pop,          // last halfword of head used
   output logic                  instr_valid,
   input  logic                  instr_ready,
   output ifu_pkg::instr_t       instr,
   output ifu_pkg::pc_t          instr_pc,
   output logic                  instr_pc4,    // 32-bit instruction
   output logic                  instr_fault   // access fault, instr is zero
);

   import ifu_pkg::*;

   logic          fresh;        // head not yet started, take its start index
   hw_idx_t       idx;          // next halfword in head
   logic          carry_valid;  // low half of a straddling instruction held
   logic [15:0]   carry_hw;
   pc_t           carry_pc;
   hw_idx_t       cur_idx;
   hw_idx_t       nxt_idx;
   logic [15:0]   hw_lo;
   logic [15:0]   hw_hi;
   logic          out_free;     // output register can take a new instruction
   logic          step;
   logic          emit;
   logic          last;
   logic          straddle;
   instr_t        emit_instr;
   pc_t           emit_pc;
   logic          emit_pc4;
   logic          emit_fault;

   function automatic logic [15:0] hw_sel(input fetch_data_t d, input hw_idx_t i);
      return d[i*16 +: 16];
   endfunction

   assign out_free = ~instr_valid | instr_ready;
   assign step     = head_valid & out_free & ~flush;
   assign cur_idx  = fresh ? head.start : idx;
   assign hw_lo    = hw_sel(head.data, cur_idx);
   assign hw_hi    = hw_sel(head.data, cur_idx + 2'd1);  // only used below hw 3
   assign pop      = step & last;

   // **********************************************************************
   // instruction select
   // **********************************************************************

   always_comb begin
      emit       = 1'b1;
      last       = 1'b0;
      straddle   = 1'b0;
      nxt_idx    = cur_idx + 2'd1;
      emit_instr = {16'h0000, hw_lo};                     // rvc by default
      emit_pc    = {head.adr, cur_idx};
      emit_pc4   = 1'b0;
      emit_fault = 1'b0;
      if (head.fault) begin
         emit_instr = '0;                                 // one fault record
         emit_pc    = {head.adr, head.start};
         emit_fault = 1'b1;
         last       = 1'b1;
      end else if (carry_valid) begin
         emit_instr = {hw_lo, carry_hw};                  // upper half at hw 0
         emit_pc    = carry_pc;
         emit_pc4   = 1'b1;
      end else if (hw_lo[1:0] == 2'b11) begin
         emit_pc4 = 1'b1;
         if (cur_idx == 2'd3) begin
            emit     = 1'b0;                              // wait for next group
            straddle = 1'b1;
            last     = 1'b1;
         end else begin
            emit_instr = {hw_hi, hw_lo};
            nxt_idx    = cur_idx + 2'd2;
            last       = (cur_idx == 2'd2);
         end
      end else begin
         last = (cur_idx == 2'd3);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         instr_valid <= 1'b0;
         fresh       <= 1'b1;
         idx         <= '0;
         carry_valid <= 1'b0;
      end else if (flush) begin
         instr_valid <= 1'b0;                   // old path never reaches decode
         fresh       <= 1'b1;
         carry_valid <= 1'b0;
      end else begin
         if (out_free) instr_valid <= step & emit;
         if (step) begin
            fresh       <= last;                // next head starts fresh
            idx         <= nxt_idx;
            carry_valid <= straddle;
         end
      end
   end

   // output payload only moves on a load, so it holds under stall
   always_ff @(posedge clk) begin
      if (step & emit) begin
         instr       <= emit_instr;
         instr_pc    <= emit_pc;
         instr_pc4   <= emit_pc4;
         instr_fault <= emit_fault;
      end
      if (step & straddle) begin
         carry_hw <= hw_lo;
         carry_pc <= emit_pc;
      end
   end

endmodule

`default_nettype wire

// File: rtl/ifu_bus_watchdog.sv
/* bus watchdog: counts cycles a strobe waits and flags the cycle as lost
   once the count reaches the timeout */

`timescale 1ns/100ps
`default_nettype none

`include "ifu_defines.svh"

module ifu_bus_watchdog (
   input  logic clk,
   input  logic rst_n,
   input  logic waiting,   // strobe out without ack or err
   output logic expired
);

   localparam int unsigned LIMIT = `IFU_BUS_TIMEOUT;

   logic [`IFU_TMR_W-1:0] cnt;   // consecutive waiting cycles

   assign expired = (cnt == LIMIT[`IFU_TMR_W-1:0]);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (!waiting) begin
         cnt <= '0;                // cleared between cycles
      end else if (!expired) begin
         cnt <= cnt + 1'b1;        // holds at the limit
      end
   end

endmodule

`default_nettype wire

// File: rtl/ifu_defines.svh
/* fetch unit constants for reset PC, buffer depth and bus timeout
   included by every RTL block that sizes or times against them */

`ifndef IFU_DEFINES_SVH
`define IFU_DEFINES_SVH

// **************************************************************************
// fetch start
// **************************************************************************

`define IFU_RESET_PC     32'h0000_0000  // first fetch PC after reset

// **************************************************************************
// fetch buffer
// **************************************************************************

`define IFU_FB_DEPTH     4              // fetch groups held between bus and aligner

// **************************************************************************
// bus watchdog
// **************************************************************************

`define IFU_BUS_TIMEOUT  16             // cycles a strobe may wait for ack or err
`define IFU_TMR_W        5              // counter width, must hold IFU_BUS_TIMEOUT

`endif

// File: rtl/ifu_fetch_buf.sv
/* fetch buffer: circular FIFO of fetch entries between the bus master and
   the aligner, emptied by a flush */

`timescale 1ns/100ps
`default_nettype none

`include "ifu_defines.svh"

module ifu_fetch_buf (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  flush,
   input  logic                  push,
   input  ifu_pkg::fetch_entry_t push_entry,
   output logic                  space,       // at least one free slot
   output logic                  head_valid,
   output ifu_pkg::fetch_entry_t head,
   input  logic                  pop
);

   import ifu_pkg::*;

   localparam int DEPTH = `IFU_FB_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   fetch_entry_t     mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;    // entries in use
   logic             do_push;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;   // wrap for any depth
   endfunction

   assign space      = (count != CNT_W'(DEPTH));
   assign head_valid = (count != '0);
   assign head       = mem[rd_ptr];

   assign do_push = push & space & ~flush;
   assign do_pop  = pop & head_valid & ~flush;

   // **********************************************************************
   // pointers and occupancy
   // **********************************************************************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (flush) begin
         wr_ptr <= '0;                          // drop every queued group
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= ptr_inc(wr_ptr);
         if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
         if (do_push & ~do_pop) count <= count + 1'b1;
         else if (do_pop & ~do_push) count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= push_entry;  // seen at head next cycle
   end

endmodule

`default_nettype wire

// File: rtl/ifu_fetch_ctl.sv
/* fetch FSM: runs the Wishbone classic read master and pushes fetch groups
   or fault entries into the fetch buffer */

`timescale 1ns/100ps
`default_nettype none

`include "ifu_defines.svh"

module ifu_fetch_ctl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 flush,       // redirect, wins over everything
   input  ifu_pkg::pc_t         flush_pc,
   output logic                 wb_cyc,
   output logic                 wb_stb,
   output ifu_pkg::fetch_adr_t  wb_adr,
   input  ifu_pkg::fetch_data_t wb_dat,
   input  logic                 wb_ack,
   input  logic                 wb_err,
   input  logic                 expired,     // watchdog gave up on this cycle
   output logic                 waiting,     // strobe out, no ack or err yet
   input  logic                 space,       // buffer can take one more group
   output logic                 push,
   output ifu_pkg::fetch_entry_t push_entry
);

   import ifu_pkg::*;

   localparam logic [31:0] RESET_PC = `IFU_RESET_PC;

   fetch_state_t state;
   fetch_state_t state_nxt;
   fetch_adr_t   fetch_adr;    // next group to fetch
   hw_idx_t      start_idx;    // start halfword of that group
   logic         done;         // WB cycle ends this edge
   logic         bad;          // and it ends as a fault
   logic         launch;       // strobe rises next cycle

   assign wb_cyc  = (state == REQ) | (state == DRAIN);  // cyc and stb move together
   assign wb_stb  = wb_cyc;
   assign waiting = wb_stb & ~wb_ack & ~wb_err;

   assign done   = wb_ack | wb_err | expired;
   assign bad    = wb_err | (expired & ~wb_ack);        // late ack still counts
   assign launch = (state == IDLE) & space & ~flush;
   assign push   = (state == REQ) & done & ~flush;      // DRAIN data never pushed

   always_comb begin
      push_entry.data  = bad ? '0 : wb_dat;
      push_entry.adr   = wb_adr;
      push_entry.start = start_idx;
      push_entry.fault = bad;
   end

   // **********************************************************************
   // next state
   // **********************************************************************

   always_comb begin
      state_nxt = state;
      if (flush) begin
         state_nxt = (wb_cyc & ~done) ? DRAIN : IDLE;  // let an open cycle finish
      end else begin
         case (state)
            IDLE:    if (space) state_nxt = REQ;
            REQ:     if (bad) state_nxt = HALT;
                     else if (done) state_nxt = IDLE;
            DRAIN:   if (done) state_nxt = IDLE;
            HALT:    state_nxt = HALT;                  // only a flush gets out
            default: state_nxt = IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= IDLE;
         fetch_adr <= RESET_PC[31:3];
         start_idx <= RESET_PC[2:1];
      end else begin
         state <= state_nxt;
         if (flush) begin
            fetch_adr <= flush_pc[31:3];             // new path
            start_idx <= flush_pc[2:1];
         end else if (push & ~bad) begin
            fetch_adr <= fetch_adr + 1'b1;            // one doubleword on
            start_idx <= '0;                          // later groups start at hw 0
         end
      end
   end

   // bus address is held for the whole cycle, even across a flush
   always_ff @(posedge clk) begin
      if (launch) wb_adr <= fetch_adr;
   end

endmodule

`default_nettype wire

// File: rtl/ifu_pkg.sv
/* types shared by the fetch unit blocks and the testbench checker */

`default_nettype none

package ifu_pkg;

   // **********************************************************************
   // address and data
   // **********************************************************************

   typedef logic [31:1] pc_t;          // halfword PC
   typedef logic [31:3] fetch_adr_t;   // doubleword fetch address, also the WB address
   typedef logic [63:0] fetch_data_t;  // one fetch group
   typedef logic [31:0] instr_t;       // rvc sits in low half, upper zero
   typedef logic [1:0]  hw_idx_t;      // halfword index within a group

   // **********************************************************************
   // fetch buffer entry
   // **********************************************************************

   typedef struct packed {
      fetch_data_t data;   // group data, zero on fault
      fetch_adr_t  adr;    // group address
      hw_idx_t     start;  // first valid halfword, nonzero only after redirect
      logic        fault;  // bus error or timeout on this group
   } fetch_entry_t;

   // fetch FSM states
   typedef enum logic [1:0] {
      IDLE,    // between cycles, waits for buffer space
      REQ,     // WB cycle in flight, data kept
      DRAIN,   // WB cycle in flight after flush, data dropped
      HALT     // fault seen, wait for flush
   } fetch_state_t;

endpackage

`default_nettype wire

// File: rtl/ifu_top.sv
/* fetch unit top: Wishbone read master, watchdog, fetch buffer and aligner
   wired between the instruction bus and decode */

`timescale 1ns/100ps
`default_nettype none

module ifu_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 flush,
   input  ifu_pkg::pc_t         flush_pc,
   output logic                 wb_cyc,
   output logic                 wb_stb,
   output ifu_pkg::fetch_adr_t  wb_adr,
   input  ifu_pkg::fetch_data_t wb_dat,
   input  logic                 wb_ack,
   input  logic                 wb_err,
   output logic                 instr_valid,
   input  logic                 instr_ready,
   output ifu_pkg::instr_t      instr,
   output ifu_pkg::pc_t         instr_pc,
   output logic                 instr_pc4,
   output logic                 instr_fault
);

   import ifu_pkg::*;

   logic         waiting;      // strobe open, watchdog counts
   logic         expired;
   logic         space;
   logic         push;
   fetch_entry_t push_entry;
   logic         head_valid;
   fetch_entry_t head;
   logic         pop;

   // bus side
   ifu_fetch_ctl u_fetch_ctl (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .flush_pc   (flush_pc),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_adr     (wb_adr),
      .wb_dat     (wb_dat),
      .wb_ack     (wb_ack),
      .wb_err     (wb_err),
      .expired    (expired),
      .waiting    (waiting),
      .space      (space),
      .push       (push),
      .push_entry (push_entry)
   );

   ifu_bus_watchdog u_watchdog (
      .clk     (clk),
      .rst_n   (rst_n),
      .waiting (waiting),
      .expired (expired)
   );

   ifu_fetch_buf u_fetch_buf (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .push       (push),
      .push_entry (push_entry),
      .space      (space),
      .head_valid (head_valid),
      .head       (head),
      .pop        (pop)
   );

   // decode side
   ifu_aligner u_aligner (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .head_valid  (head_valid),
      .head        (head),
      .pop         (pop),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .instr       (instr),
      .instr_pc    (instr_pc),
      .instr_pc4   (instr_pc4),
      .instr_fault (instr_fault)
   );

endmodule

`default_nettype wire

// File: sim/ifu_checker.sv
/* bus and decode handshake assertions bound into the fetch unit top */

`timescale 1ns/100ps
`default_nettype none

module ifu_checker (
   input logic                 clk,
   input logic                 rst_n,
   input logic                 flush,
   input logic                 wb_cyc,
   input logic                 wb_stb,
   input ifu_pkg::fetch_adr_t  wb_adr,
   input logic                 wb_ack,
   input logic                 wb_err,
   input logic                 instr_valid,
   input logic                 instr_ready,
   input ifu_pkg::instr_t      instr,
   input ifu_pkg::pc_t         instr_pc,
   input logic                 instr_pc4,
   input logic                 instr_fault
);

   stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
      else $error("wb_stb high without wb_cyc");

   // address held while the strobe waits
   adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (wb_stb & ~wb_ack & ~wb_err) |=> $stable(wb_adr))
      else $error("wb_adr moved during a waiting strobe");

   out_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (instr_valid & ~instr_ready & ~flush) |=>
         (instr_valid & $stable(instr) & $stable(instr_pc) & $stable(instr_pc4)
          & $stable(instr_fault)))
      else $error("decode outputs changed under stall");

   rst_quiet: assert property (@(posedge clk) !rst_n |-> (!instr_valid & !wb_cyc))
      else $error("outputs active during reset");

endmodule

bind ifu_top ifu_checker u_checker (
   .clk         (clk),
   .rst_n       (rst_n),
   .flush       (flush),
   .wb_cyc      (wb_cyc),
   .wb_stb      (wb_stb),
   .wb_adr      (wb_adr),
   .wb_ack      (wb_ack),
   .wb_err      (wb_err),
   .instr_valid (instr_valid),
   .instr_ready (instr_ready),
   .instr       (instr),
   .instr_pc    (instr_pc),
   .instr_pc4   (instr_pc4),
   .instr_fault (instr_fault)
);

`default_nettype wire

// File: sim/ifu_input.txt
# m <byte adr> <64-bit group>   f <after n records> <quiet cycles> <flush pc>
# i <pc> <instr> <pc4>          x <fault pc>
m 00000000 051300a000934501
m 00000008 4585000180820010
m 00000010 40b5053300b50633
m 00000018 0297460100c58593
m 00000020 4781470146810000
m 00000040 0393777766665555
m 00000048 0100081348010070
m 000003f8 4985490548859999
m 00000050 4505450100100073
i 00000000 00004501 0
i 00000002 00a00093 1
i 00000006 00100513 1
i 0000000a 00008082 0
i 0000000c 00000001 0
i 0000000e 00004585 0
i 00000010 00b50633 1
i 00000014 40b50533 1
i 00000018 00c58593 1
i 0000001c 00004601 0
i 0000001e 00000297 1
i 00000022 00004681 0
i 00000024 00004701 0
i 00000026 00004781 0
f 14 0 00000046
i 00000046 00700393 1
i 0000004a 00004801 0
i 0000004c 01000813 1
f 17 0 000003fa
i 000003fa 00004885 0
i 000003fc 00004905 0
i 000003fe 00004985 0
x 00000400
f 21 30 00000602
x 00000602
f 22 30 00000050
i 00000050 00100073 1
i 00000054 00004501 0
i 00000056 00004505 0

// File: sim/ifu_tb.sv
/* fetch unit testbench reading its memory image, flushes and expected
   instruction records from sim/ifu_input.txt while decode stalls at random */

`timescale 1ns/100ps
`default_nettype none

module ifu_tb;

   import ifu_pkg::*;

   logic        clk;
   logic        rst_n;
   logic        flush;
   pc_t         flush_pc;
   logic        wb_cyc;
   logic        wb_stb;
   fetch_adr_t  wb_adr;
   fetch_data_t wb_dat;
   logic        wb_ack;
   logic        wb_err;
   logic        instr_valid;
   logic        instr_ready;
   instr_t      instr;
   pc_t         instr_pc;
   logic        instr_pc4;
   logic        instr_fault;

   integer      seed = 14644;
   logic        exp_fault_q [$];   // expected records in order
   pc_t         exp_pc_q [$];
   instr_t      exp_instr_q [$];
   logic        exp_pc4_q [$];
   int          fl_after_q [$];    // flush after this many records
   int          fl_delay_q [$];    // quiet cycles checked before it
   pc_t         fl_pc_q [$];
   fetch_adr_t  ld_adr_q [$];
   fetch_data_t ld_dat_q [$];
   int          limit = 0;
   int          cycles = 0;

   ifu_top uut (.*);

   ifu_wb_mem u_mem (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_instr(input pc_t exp_pc, input instr_t exp_instr, input logic exp_pc4);
      if (instr_fault !== 1'b0 || instr_pc !== exp_pc || instr !== exp_instr
          || instr_pc4 !== exp_pc4)
         report_fail($sformatf("ERR %0t: pc %h instr %h pc4 %b fault %b, expected pc %h %h %b",
            $time, {instr_pc, 1'b0}, instr, instr_pc4, instr_fault,
            {exp_pc, 1'b0}, exp_instr, exp_pc4));
   endtask

   task automatic check_fault(input pc_t exp_pc, input logic exp_fault);
      if (instr_fault !== exp_fault || instr_pc !== exp_pc)
         report_fail($sformatf("ERR %0t: fault %b at pc %h, expected fault %b at pc %h",
            $time, instr_fault, {instr_pc, 1'b0}, exp_fault, {exp_pc, 1'b0}));
   endtask

   task automatic read_input();
      int          fd;
      string       line;
      string       tag;
      logic [31:0] a;
      logic [63:0] d;
      logic [31:0] w;
      int          n1;
      int          n2;
      fd = $fopen("sim/ifu_input.txt", "r");
      if (fd == 0) begin
         report_fail("could not open the input file sim/ifu_input.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%s", tag) == 1) begin
               case (tag)
                  "m": if ($sscanf(line, "%s %h %h", tag, a, d) == 3) begin
                     ld_adr_q.push_back(a[31:3]);
                     ld_dat_q.push_back(d);
                  end
                  "f": if ($sscanf(line, "%s %d %d %h", tag, n1, n2, a) == 4) begin
                     fl_after_q.push_back(n1);
                     fl_delay_q.push_back(n2);
                     fl_pc_q.push_back(a[31:1]);
                  end
                  "i": if ($sscanf(line, "%s %h %h %d", tag, a, w, n1) == 4) begin
                     exp_fault_q.push_back(1'b0);
                     exp_pc_q.push_back(a[31:1]);
                     exp_instr_q.push_back(w);
                     exp_pc4_q.push_back(n1 != 0);
                  end
                  "x": if ($sscanf(line, "%s %h", tag, a) == 2) begin
                     exp_fault_q.push_back(1'b1);
                     exp_pc_q.push_back(a[31:1]);
                     exp_instr_q.push_back('0);
                     exp_pc4_q.push_back(1'b0);
                  end
                  default: ;   // comment lines
               endcase
            end
         end
         $fclose(fd);
      end
   endtask

   // stall decode and keep both bus and decode quiet for delay cycles before the redirect
   task automatic apply_flush(input int delay, input pc_t pc);
      instr_ready = 1'b0;
      for (int i = 0; i < delay; i++) begin
         @(negedge clk);
         if (instr_valid)
            report_fail("an instruction came out after an access fault, before the flush");
         else if (wb_cyc)
            report_fail("a bus cycle started after an access fault, before the flush");
      end
      flush    = 1'b1;
      flush_pc = pc;
      @(negedge clk);
      flush = 1'b0;
   endtask

   // **************************************************************************
   // run limit
   // **************************************************************************

   initial begin
      wait (limit != 0);
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles >= limit)
            report_fail("timeout, the expected instructions did not all arrive");
      end
   end

   // **************************************************************************
   // stimulus and checking
   // **************************************************************************

   initial begin
      int nrecv;
      int fl_idx;
      rst_n       = 1'b0;
      flush       = 1'b0;
      flush_pc    = '0;
      instr_ready = 1'b0;
      nrecv       = 0;
      fl_idx      = 0;
      read_input();
      limit = 64 * exp_pc_q.size() + 200;
      @(negedge clk);
      foreach (ld_adr_q[k]) u_mem.load(ld_adr_q[k], ld_dat_q[k]);
      repeat (2) @(negedge clk);
      rst_n = 1'b1;                                // 3 cycles of reset
      while (nrecv < exp_pc_q.size()) begin
         @(negedge clk);
         if (fl_idx < fl_after_q.size() && fl_after_q[fl_idx] == nrecv) begin
            apply_flush(fl_delay_q[fl_idx], fl_pc_q[fl_idx]);
            fl_idx++;
         end else begin
            instr_ready = (($random(seed) & 3) != 0);    // stall about one cycle in four
            if (instr_valid && instr_ready) begin        // transfer on the next edge
               if (exp_fault_q[nrecv])
                  check_fault(exp_pc_q[nrecv], 1'b1);
               else
                  check_instr(exp_pc_q[nrecv], exp_instr_q[nrecv], exp_pc4_q[nrecv]);
               nrecv++;
            end
         end
      end
      @(negedge clk);
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/ifu_wb_mem.sv
/* Wishbone classic read memory for the testbench, random ack delay,
   an error region at 0x400-0x4ff and a silent region at 0x600-0x6ff */

`timescale 1ns/100ps
`default_nettype none

module ifu_wb_mem (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 wb_cyc,
   input  logic                 wb_stb,
   input  ifu_pkg::fetch_adr_t  wb_adr,
   output ifu_pkg::fetch_data_t wb_dat,
   output logic                 wb_ack,
   output logic                 wb_err
);

   import ifu_pkg::*;

   fetch_data_t mem [0:255];   // byte addresses 0x000-0x7ff
   integer      seed = 14644;
   logic        busy;          // strobe seen, delay picked
   logic [1:0]  wait_cnt;

   task automatic load(input fetch_adr_t adr, input fetch_data_t dat);
      mem[adr[10:3]] = dat;
   endtask

   // fill tracks the whole word index
   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[i] = {8'hf0, i[7:0], 8'he1, i[7:0], 8'hd2, i[7:0], 8'hc3, i[7:0]};
      end
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_ack   <= 1'b0;
         wb_err   <= 1'b0;
         wb_dat   <= '0;
         busy     <= 1'b0;
         wait_cnt <= '0;
      end else if (wb_ack | wb_err) begin
         wb_ack <= 1'b0;                            // one-cycle response
         wb_err <= 1'b0;
         busy   <= 1'b0;
      end else if (wb_cyc & wb_stb) begin
         if (wb_adr[31:8] == 24'h6) begin
            busy <= 1'b1;                           // silent region, never answers
         end else if (!busy) begin
            busy     <= 1'b1;
            wait_cnt <= 2'($random(seed) & 3);
         end else if (wait_cnt != 0) begin
            wait_cnt <= wait_cnt - 1'b1;
         end else if (wb_adr[31:8] == 24'h4) begin
            wb_err <= 1'b1;                         // error region
         end else begin
            wb_ack <= 1'b1;
            wb_dat <= mem[wb_adr[10:3]];
         end
      end else begin
         busy <= 1'b0;
      end
   end

endmodule

`default_nettype wire
